//--- mem_ctrl.f
src/mem_pkg.sv
src/client_port.sv
src/byte_sequencer.sv
src/load_assembler.sv
src/mem_ctrl.sv
testbench/mem_ctrl_props.sv
testbench/tb_mem_ctrl.sv

//--- run.sh
#!/usr/bin/env bash
# compile the memory controller testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_ctrl -f mem_ctrl.f \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/Vtb_mem_ctrl 2>&1)
echo "$out"
echo "$out" | grep -qxF "PASS: all tests" && echo "result: passed" \
    || { echo "result: failed"; exit 1; }

//--- testbench/tb_mem_ctrl.sv
/* memory controller testbench, two random clients on the req/ack ports,
   a byte-wide ram model on the bus and a reference copy of the memory */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_ctrl;

    import mem_pkg::*;

    localparam int mem_bytes = 131072;          // 128 KB
    localparam int ack_limit = 400;             // cycles per handshake edge
    localparam int ls_ops    = 80;
    localparam int fetch_ops = 60;

    logic      clk_in;
    logic      rst_in;
    logic      rdy_in;
    logic      fetch_req;
    word_t     fetch_pc;
    logic      fetch_ack;
    word_t     fetch_inst;
    logic      ls_req;
    logic      ls_is_store;
    ls_width_t ls_width;
    word_t     ls_addr;
    word_t     ls_wdata;
    logic      ls_ack;
    word_t     ls_rdata;
    byte_t     mem_din;
    byte_t     mem_dout;
    word_t     mem_a;
    logic      mem_wr;

    byte_t       ram     [mem_bytes];           // bus side memory
    byte_t       ref_mem [mem_bytes];           // expected contents, updated on store ack
    logic [16:0] rd_addr_q = '0;                // address seen in the last cycle
    int          wr_count  = 0;                 // bus write cycles so far
    logic        random_done;

    mem_ctrl i_dut (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .rdy_in      (rdy_in),
        .fetch_req   (fetch_req),
        .fetch_pc    (fetch_pc),
        .fetch_ack   (fetch_ack),
        .fetch_inst  (fetch_inst),
        .ls_req      (ls_req),
        .ls_is_store (ls_is_store),
        .ls_width    (ls_width),
        .ls_addr     (ls_addr),
        .ls_wdata    (ls_wdata),
        .ls_ack      (ls_ack),
        .ls_rdata    (ls_rdata),
        .mem_din     (mem_din),
        .mem_dout    (mem_dout),
        .mem_a       (mem_a),
        .mem_wr      (mem_wr)
    );

    bind mem_ctrl mem_ctrl_props i_props (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .rdy_in    (rdy_in),
        .fetch_req (fetch_req),
        .fetch_ack (fetch_ack),
        .ls_req    (ls_req),
        .ls_ack    (ls_ack),
        .mem_a     (mem_a),
        .mem_wr    (mem_wr)
    );

    initial
    begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;            // 8 ns period
    end

    function automatic byte_t fill_byte(int a);
        return byte_t'((a * 7) ^ (a >> 8) ^ (a >> 15));  // every address bit matters
    endfunction

    function automatic logic [16:0] ram_index(word_t a);
        return a[16:0];
    endfunction

    // ram model, writes land at the clock edge, read data follows one cycle late
    initial
    begin
        for (int i = 0; i < mem_bytes; i++)
            ram[17'(i)] = fill_byte(i);
        forever
        begin
            @(posedge clk_in);
            if (mem_wr)
            begin
                ram[mem_a[16:0]] = mem_dout;
                wr_count = wr_count + 1;
            end
            rd_addr_q = mem_a[16:0];
        end
    end

    initial
    begin
        mem_din = '0;
        forever
        begin
            @(negedge clk_in);
            mem_din = ram[rd_addr_q];           // valid through the next cycle
        end
    end

    function automatic int access_size(ls_width_t w);
        if (w[1:0] == 2'd0)
            return 1;
        if (w[1:0] == 2'd1)
            return 2;
        return 4;
    endfunction

    function automatic ls_width_t width_code(int k);
        case (k)
            0:       return lsw_byte;
            1:       return lsw_half;
            2:       return lsw_word;
            3:       return lsw_byte_u;
            default: return lsw_half_u;
        endcase
    endfunction

    // little endian gather from the reference memory, then extension
    function automatic word_t expect_load(ls_width_t w, word_t a);
        word_t v;
        int    n;
        v = '0;
        n = access_size(w);
        for (int i = 0; i < n; i++)
            v = v | (word_t'(ref_mem[ram_index(a + word_t'(i))]) << (8 * i));
        if (!w[2] && n < 4 && ((v >> (8 * n - 1)) & word_t'(1)) != '0)
            v = v | ~((word_t'(1) << (8 * n)) - word_t'(1));  // copy the sign bit up
        return v;
    endfunction

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
        begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp)
        begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    // sampled on falling edges, ack only moves on rising ones
    task automatic wait_ack(input logic is_ls, input logic level);
        int n;
        n = 0;
        while ((is_ls ? ls_ack : fetch_ack) !== level)
        begin
            @(negedge clk_in);
            n++;
            if (n > ack_limit)
            begin
                $display("timeout: %s ack did not go %0b within %0d cycles",
                         is_ls ? "load/store" : "fetch", level, ack_limit);
                abort_run();
            end
        end
    endtask

    task automatic run_ls(input logic st, input ls_width_t w, input word_t a,
                          input word_t d);
        int    wr_before;
        int    wr_exp;
        word_t r;
        @(negedge clk_in);
        check_bit("ls_ack", ls_ack, 1'b0);      // last handshake closed
        ls_is_store = st;
        ls_width    = w;
        ls_addr     = a;
        ls_wdata    = d;
        ls_req      = 1'b1;
        wr_before   = wr_count;
        wait_ack(1'b1, 1'b1);
        r      = ls_rdata;
        wr_exp = st ? access_size(w) : 0;
        if (wr_count - wr_before != wr_exp)
        begin
            $display("access at %h made %0d bus writes, %0d were due",
                     a, wr_count - wr_before, wr_exp);
            abort_run();
        end
        ls_req = 1'b0;
        wait_ack(1'b1, 1'b0);
        if (st)
        begin
            for (int i = 0; i < access_size(w); i++)
            begin
                ref_mem[ram_index(a + word_t'(i))] = byte_t'(d >> (8 * i));
                check_byte($sformatf("ram[%h]", a + word_t'(i)),
                           ram[ram_index(a + word_t'(i))],
                           ref_mem[ram_index(a + word_t'(i))]);
            end
        end
        else
            check_word("ls_rdata", r, expect_load(w, a));
    endtask

    task automatic run_fetch(input word_t pc);
        @(negedge clk_in);
        check_bit("fetch_ack", fetch_ack, 1'b0);
        fetch_pc  = pc;
        fetch_req = 1'b1;
        wait_ack(1'b0, 1'b1);
        check_word("fetch_inst", fetch_inst, expect_load(lsw_word, pc));
        fetch_req = 1'b0;
        wait_ack(1'b0, 1'b0);
    endtask

    task automatic ls_traffic();
        ls_width_t w;
        word_t     a;
        for (int i = 0; i < ls_ops; i++)
        begin
            w = width_code(int'($urandom % 5));
            a = (32'h0000_8000 + ($urandom % 32'h8000)) & ~(word_t'(access_size(w) - 1));
            run_ls(1'($urandom % 2), w, a, $urandom);
            repeat ($urandom % 3) @(negedge clk_in);
        end
    endtask

    task automatic fetch_traffic();
        for (int i = 0; i < fetch_ops; i++)
        begin
            run_fetch(($urandom % 32'h8000) & ~32'd3);   // below the ls region
            repeat ($urandom % 3) @(negedge clk_in);
        end
    endtask

    // random rdy_in drops of 1 to 4 cycles
    task automatic rdy_pauses();
        int stretch;
        int n;
        stretch = 0;
        n = 0;
        while (!random_done)
        begin
            @(negedge clk_in);
            n++;
            if (n > 40 * ack_limit)
            begin
                $display("timeout: random traffic did not finish in %0d cycles", n);
                abort_run();
            end
            if (stretch > 0)
            begin
                stretch--;
                rdy_in = (stretch == 0);
            end
            else if ($urandom % 5 == 0)
            begin
                stretch = 1 + int'($urandom % 4);
                rdy_in  = 1'b0;
            end
        end
        rdy_in = 1'b1;
    endtask

    initial
    begin
        void'($urandom(32'h3b47));
        rst_in      = 1'b1;
        rdy_in      = 1'b1;
        fetch_req   = 1'b0;
        fetch_pc    = '0;
        ls_req      = 1'b0;
        ls_is_store = 1'b0;
        ls_width    = lsw_word;
        ls_addr     = '0;
        ls_wdata    = '0;
        random_done = 1'b0;
        for (int i = 0; i < mem_bytes; i++)
            ref_mem[17'(i)] = fill_byte(i);
        repeat (3) @(posedge clk_in);
        @(negedge clk_in);
        rst_in = 1'b0;

        check_bit("fetch_ack", fetch_ack, 1'b0);     // idle after reset
        check_bit("ls_ack", ls_ack, 1'b0);
        check_bit("mem_wr", mem_wr, 1'b0);
        check_word("mem_a", mem_a, '0);
        check_byte("mem_dout", mem_dout, '0);

        for (int k = 0; k < 5; k++)
        begin
            // sign bits of byte and half set so extension shows
            run_ls(1'b1, width_code(k), 32'h0001_2340 + word_t'(8 * k),
                   $urandom | 32'h0000_8080);
            run_ls(1'b0, width_code(k), 32'h0001_2340 + word_t'(8 * k), '0);
        end

        for (int k = 0; k < 4; k++)
        begin
            run_ls(1'b1, lsw_word, 32'h0000_0400 + word_t'(4 * k), $urandom);
            run_fetch(32'h0000_0400 + word_t'(4 * k));   // fresh store visible
        end
        run_fetch(32'h0000_0800);
        run_fetch(32'h0001_FFFC);                         // top word of the ram

        // both raised in one cycle, load/store goes first
        @(negedge clk_in);
        fetch_pc    = 32'h0000_0900;
        fetch_req   = 1'b1;
        ls_is_store = 1'b0;
        ls_width    = lsw_half;
        ls_addr     = 32'h0000_0a02;
        ls_req      = 1'b1;
        wait_ack(1'b1, 1'b1);
        check_bit("fetch_ack", fetch_ack, 1'b0);
        check_word("ls_rdata", ls_rdata, expect_load(lsw_half, 32'h0000_0a02));
        ls_req = 1'b0;
        wait_ack(1'b0, 1'b1);
        check_word("fetch_inst", fetch_inst, expect_load(lsw_word, 32'h0000_0900));
        fetch_req = 1'b0;
        wait_ack(1'b0, 1'b0);
        wait_ack(1'b1, 1'b0);

        fork
            begin
                fork
                    ls_traffic();
                    fetch_traffic();
                join
                random_done = 1'b1;
            end
            rdy_pauses();
        join

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/mem_ctrl_props.sv
/* concurrent checks on the memory controller top, bound to mem_ctrl
   four-phase ack order and memory bus address and write rules */
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl_props (
    input logic           clk_in,
    input logic           rst_in,
    input logic           rdy_in,
    input logic           fetch_req,
    input logic           fetch_ack,
    input logic           ls_req,
    input logic           ls_ack,
    input mem_pkg::word_t mem_a,
    input logic           mem_wr
);

    import mem_pkg::*;

    // ack answers a request that was up in the cycle it rose
    fetch_ack_rise: assert property (@(posedge clk_in) disable iff (rst_in)
        $rose(fetch_ack) |-> $past(fetch_req))
        else $error("fetch_ack rose while fetch_req was low");

    ls_ack_rise: assert property (@(posedge clk_in) disable iff (rst_in)
        $rose(ls_ack) |-> $past(ls_req))
        else $error("ls_ack rose while ls_req was low");

    // release only after the client let go
    fetch_ack_fall: assert property (@(posedge clk_in) disable iff (rst_in)
        $fell(fetch_ack) |-> !$past(fetch_req))
        else $error("fetch_ack fell while fetch_req was high");

    ls_ack_fall: assert property (@(posedge clk_in) disable iff (rst_in)
        $fell(ls_ack) |-> !$past(ls_req))
        else $error("ls_ack fell while ls_req was high");

    addr_range: assert property (@(posedge clk_in) disable iff (rst_in)
        mem_a <= mem_top_addr)
        else $error("mem_a beyond the 128 KB ram");

    // no client busy means no transfer on the bus
    addr_idle: assert property (@(posedge clk_in) disable iff (rst_in)
        (!fetch_req && !ls_req && !fetch_ack && !ls_ack) |-> mem_a == '0)
        else $error("mem_a not zero while idle");

    wr_stall: assert property (@(posedge clk_in) disable iff (rst_in)
        !rdy_in |-> !mem_wr)
        else $error("mem_wr high during a pause");

endmodule

`default_nettype wire

//--- src/mem_ctrl.sv
/* memory controller top, shares the byte-wide ram bus between
   an instruction fetch client and a load/store client */
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl (
    input  logic               clk_in,
    input  logic               rst_in,
    input  logic               rdy_in,      // pause everything when low
    input  logic               fetch_req,
    input  mem_pkg::word_t     fetch_pc,
    output logic               fetch_ack,
    output mem_pkg::word_t     fetch_inst,
    input  logic               ls_req,
    input  logic               ls_is_store,
    input  mem_pkg::ls_width_t ls_width,
    input  mem_pkg::word_t     ls_addr,
    input  mem_pkg::word_t     ls_wdata,
    output logic               ls_ack,
    output mem_pkg::word_t     ls_rdata,
    input  mem_pkg::byte_t     mem_din,     // read byte, one cycle after address
    output mem_pkg::byte_t     mem_dout,
    output mem_pkg::word_t     mem_a,
    output logic               mem_wr       // 1 write, 0 read
);

    import mem_pkg::*;

    fetch_req_t  fetch_payload;
    fetch_req_t  fetch_held;
    ls_req_t     ls_payload;
    ls_req_t     ls_held;
    logic        fetch_pending;
    logic        ls_pending;
    logic        fetch_done;
    logic        ls_done;
    client_sel_t owner;
    ls_width_t   width;
    logic        byte_valid;
    logic [1:0]  byte_index;
    word_t       asm_result;                // valid together with done

    assign fetch_payload.pc = fetch_pc;

    assign ls_payload = '{
        is_store:   ls_is_store,
        width:      ls_width,
        addr:       ls_addr,
        store_data: ls_wdata
    };

    client_port #(
        .payload_t (fetch_req_t)
    ) i_fetch_port (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .rdy_in      (rdy_in),
        .req         (fetch_req),
        .payload     (fetch_payload),
        .ack         (fetch_ack),
        .result      (fetch_inst),
        .pending     (fetch_pending),
        .held        (fetch_held),
        .done        (fetch_done),
        .done_result (asm_result)
    );

    client_port #(
        .payload_t (ls_req_t)
    ) i_ls_port (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .rdy_in      (rdy_in),
        .req         (ls_req),
        .payload     (ls_payload),
        .ack         (ls_ack),
        .result      (ls_rdata),
        .pending     (ls_pending),
        .held        (ls_held),
        .done        (ls_done),
        .done_result (asm_result)
    );

    byte_sequencer i_seq (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .rdy_in        (rdy_in),
        .fetch_pending (fetch_pending),
        .fetch_req     (fetch_held),
        .ls_pending    (ls_pending),
        .ls_req        (ls_held),
        .fetch_done    (fetch_done),
        .ls_done       (ls_done),
        .owner         (owner),
        .width         (width),
        .byte_valid    (byte_valid),
        .byte_index    (byte_index),
        .last          (),                  // already folded into the done pulses
        .mem_a         (mem_a),
        .mem_dout      (mem_dout),
        .mem_wr        (mem_wr)
    );

    load_assembler i_asm (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .rdy_in     (rdy_in),
        .byte_valid (byte_valid),
        .byte_index (byte_index),
        .mem_din    (mem_din),
        .width      (width),
        .owner      (owner),
        .result     (asm_result)
    );

endmodule

`default_nettype wire

//--- src/load_assembler.sv
/* load assembler, gathers returned read bytes by index and
   extends them to the 32-bit result for the owning client */
`timescale 1ns/1ps
`default_nettype none

module load_assembler (
    input  logic                 clk_in,
    input  logic                 rst_in,
    input  logic                 rdy_in,
    input  logic                 byte_valid,
    input  logic [1:0]           byte_index,
    input  mem_pkg::byte_t       mem_din,
    input  mem_pkg::ls_width_t   width,
    input  mem_pkg::client_sel_t owner,
    output mem_pkg::word_t       result
);

    import mem_pkg::*;

    byte_t b_q [0:2];                           // bytes 0..2 of the access
    byte_t b   [0:3];                           // registered bytes plus bus byte

    always_ff @(posedge clk_in)
    begin
        if (rst_in)
        begin
            b_q[0] <= '0;
            b_q[1] <= '0;
            b_q[2] <= '0;
        end
        else if (rdy_in && byte_valid && byte_index != 2'd3)
        begin
            b_q[byte_index] <= mem_din;
        end
    end

    always_comb
    begin
        for (int i = 0; i < 3; i++)
        begin
            // the byte on the bus this cycle overrides its stale register
            b[i] = (byte_valid && byte_index == 2'(i)) ? mem_din : b_q[i];
        end
        b[3] = mem_din;                         // byte 3 only ever arrives last

        if (owner == sel_fetch)
        begin
            result = {b[3], b[2], b[1], b[0]};  // raw instruction word
        end
        else
        begin
            case (width)
                lsw_byte:   result = {{24{b[0][7]}}, b[0]};
                lsw_half:   result = {{16{b[1][7]}}, b[1], b[0]};
                lsw_word:   result = {b[3], b[2], b[1], b[0]};
                lsw_byte_u: result = {24'd0, b[0]};
                lsw_half_u: result = {16'd0, b[1], b[0]};
                default:    result = {b[3], b[2], b[1], b[0]};
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/byte_sequencer.sv
/* byte sequencer, arbitrates the two clients and runs byte cycles
   on the 8-bit memory bus, with a one-cycle read return stage */
`timescale 1ns/1ps
`default_nettype none

module byte_sequencer (
    input  logic                 clk_in,
    input  logic                 rst_in,
    input  logic                 rdy_in,
    input  logic                 fetch_pending,
    input  mem_pkg::fetch_req_t  fetch_req,
    input  logic                 ls_pending,
    input  mem_pkg::ls_req_t     ls_req,
    output logic                 fetch_done,
    output logic                 ls_done,
    output mem_pkg::client_sel_t owner,
    output mem_pkg::ls_width_t   width,
    output logic                 byte_valid,
    output logic [1:0]           byte_index,
    output logic                 last,
    output mem_pkg::word_t       mem_a,
    output mem_pkg::byte_t       mem_dout,
    output logic                 mem_wr
);

    import mem_pkg::*;

    logic              active;                  // transfer owns the bus
    logic              is_store;
    logic [2:0]        n_bytes;                 // 1, 2 or 4
    logic [2:0]        cnt;                     // next byte to issue
    logic              rd_valid;                // read byte due on mem_din
    logic [1:0]        rd_index;
    logic              rd_last;
    logic [addr_w-1:0] base_addr;
    word_t             wdata;

    logic              issuing;
    logic              wr_last;
    logic              done;
    logic              use_rd;
    logic [1:0]        offset;
    logic [addr_w-1:0] byte_addr;
    byte_t             wbyte;

    assign issuing = active && (cnt < n_bytes);
    assign wr_last = issuing && is_store && (cnt == n_bytes - 3'd1);

    // read return, only taken in a ready cycle
    assign byte_valid = rd_valid && rdy_in;
    assign byte_index = rd_index;
    assign last       = rd_valid && rd_last && rdy_in;

    assign done       = last || (wr_last && rdy_in);
    assign fetch_done = done && (owner == sel_fetch);
    assign ls_done    = done && (owner == sel_ls);

    // during a pause the address of the byte still due is shown again,
    // so its data sits on mem_din in the first ready cycle
    assign use_rd    = rd_valid && (!rdy_in || !issuing);
    assign offset    = use_rd ? rd_index : cnt[1:0];
    assign byte_addr = (base_addr + addr_w'(offset)) & mem_top_addr; // stay inside 128 KB

    assign wbyte    = wdata[8*cnt[1:0] +: 8];   // little endian store byte
    assign mem_a    = active ? byte_addr : '0;
    assign mem_dout = (active && is_store) ? wbyte : '0;
    assign mem_wr   = issuing && is_store && rdy_in; // no repeated write on stall

    always_ff @(posedge clk_in)
    begin
        if (rst_in)
        begin
            active   <= 1'b0;
            owner    <= sel_fetch;
            width    <= lsw_word;
            is_store <= 1'b0;
            n_bytes  <= '0;
            cnt      <= '0;
            rd_valid <= 1'b0;
            rd_index <= '0;
            rd_last  <= 1'b0;
        end
        else if (rdy_in)
        begin
            if (!active)
            begin
                cnt <= '0;
                if (ls_pending)                 // ls beats fetch
                begin
                    active   <= 1'b1;
                    owner    <= sel_ls;
                    is_store <= ls_req.is_store;
                    width    <= ls_req.width;
                    n_bytes  <= bytes_of(ls_req.width);
                end
                else if (fetch_pending)
                begin
                    active   <= 1'b1;
                    owner    <= sel_fetch;
                    is_store <= 1'b0;           // fetch is always a word load
                    width    <= lsw_word;
                    n_bytes  <= 3'd4;
                end
            end
            else
            begin
                if (issuing)
                    cnt <= cnt + 3'd1;
                rd_valid <= issuing && !is_store;  // data back next cycle
                rd_index <= cnt[1:0];
                rd_last  <= (cnt == n_bytes - 3'd1);
                if (done)
                    active <= 1'b0;             // transfer always runs to the end
            end
        end
    end

    // request payload, taken when a client is picked
    always_ff @(posedge clk_in)
    begin
        if (rdy_in && !active)
        begin
            if (ls_pending)
            begin
                base_addr <= ls_req.addr;
                wdata     <= ls_req.store_data;
            end
            else if (fetch_pending)
            begin
                base_addr <= fetch_req.pc;
                wdata     <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/client_port.sv
/* client port, four-phase req/ack front end for one memory client
   captures the request payload and hands the served result back */
`timescale 1ns/1ps
`default_nettype none

module client_port #(
    parameter type payload_t = logic
) (
    input  logic           clk_in,
    input  logic           rst_in,
    input  logic           rdy_in,
    input  logic           req,
    input  payload_t       payload,
    output logic           ack,
    output mem_pkg::word_t result,
    output logic           pending,
    output payload_t       held,
    input  logic           done,
    input  mem_pkg::word_t done_result
);

    typedef enum logic [1:0] {
        st_idle,                                // waiting for req
        st_waiting,                             // captured, queued at sequencer
        st_acked                                // result out, waiting for req low
    } state_t;

    state_t state;

    always_ff @(posedge clk_in)
    begin
        if (rst_in)
        begin
            state <= st_idle;
        end
        else if (rdy_in)                        // frozen while paused
        begin
            case (state)
                st_idle:
                begin
                    if (req)
                        state <= st_waiting;
                end
                st_waiting:
                begin
                    if (done)
                        state <= st_acked;      // ack one cycle after done
                end
                st_acked:
                begin
                    if (!req)
                        state <= st_idle;       // four-phase release
                end
                default:
                    state <= st_idle;
            endcase
        end
    end

    // payload and result registers
    always_ff @(posedge clk_in)
    begin
        if (rdy_in && state == st_idle && req)
            held <= payload;                    // request stable while req high
        if (rdy_in && state == st_waiting && done)
            result <= done_result;              // assembler word valid with done
    end

    assign pending = (state == st_waiting);
    assign ack     = (state == st_acked);       // result stable while ack high

endmodule

`default_nettype wire

//--- src/mem_pkg.sv
/* memory controller shared definitions
   bus constants, access width codes and the two client request payloads */
`default_nettype none

package mem_pkg;

    localparam int addr_w = 32;                     // address bus width

    typedef logic [31:0] word_t;                    // inst, store data, load result
    typedef logic [7:0]  byte_t;                    // one bus byte
    typedef logic [2:0]  ls_width_t;                // funct3 style access code

    localparam word_t mem_top_addr = 32'h0001_FFFF; // last byte of the 128 KB ram

    localparam ls_width_t lsw_byte   = 3'd0;        // signed byte
    localparam ls_width_t lsw_half   = 3'd1;        // signed half
    localparam ls_width_t lsw_word   = 3'd2;        // full word
    localparam ls_width_t lsw_byte_u = 3'd4;        // unsigned byte
    localparam ls_width_t lsw_half_u = 3'd5;        // unsigned half

    typedef struct packed {
        word_t pc;                                  // word aligned fetch address
    } fetch_req_t;

    typedef struct packed {
        logic      is_store;                        // 1 store, 0 load
        ls_width_t width;
        word_t     addr;
        word_t     store_data;                      // ignored on loads
    } ls_req_t;

    typedef enum logic {
        sel_fetch = 1'b0,
        sel_ls    = 1'b1
    } client_sel_t;

    // number of bus cycles for an access, stores use only the size bits
    function automatic logic [2:0] bytes_of(ls_width_t w);
        case (w[1:0])
            2'd0:    return 3'd1;
            2'd1:    return 3'd2;
            default: return 3'd4;
        endcase
    endfunction

endpackage

`default_nettype wire
